//--- verilog/cu_pkg.sv
package cu_pkg;

    // Instruction fields
    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;

    localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'h00;
    localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'h08;
    localparam logic [OPCODE_W-1:0] OP_ADDIU = 6'h09;
    localparam logic [OPCODE_W-1:0] OP_LW    = 6'h23;
    localparam logic [OPCODE_W-1:0] OP_LH    = 6'h21;
    localparam logic [OPCODE_W-1:0] OP_LB    = 6'h20;

    localparam logic [FUNCT_W-1:0] FN_ADD = 6'h20;
    localparam logic [FUNCT_W-1:0] FN_AND = 6'h24;
    localparam logic [FUNCT_W-1:0] FN_SUB = 6'h22;

    // Instruction classes
    localparam int CLS_W = 4;

    localparam logic [CLS_W-1:0] CLS_ADD     = 4'd0;
    localparam logic [CLS_W-1:0] CLS_AND     = 4'd1;
    localparam logic [CLS_W-1:0] CLS_SUB     = 4'd2;
    localparam logic [CLS_W-1:0] CLS_ADDI    = 4'd3;
    localparam logic [CLS_W-1:0] CLS_ADDIU   = 4'd4;
    localparam logic [CLS_W-1:0] CLS_LW      = 4'd5;
    localparam logic [CLS_W-1:0] CLS_LH      = 4'd6;
    localparam logic [CLS_W-1:0] CLS_LB      = 4'd7;
    localparam logic [CLS_W-1:0] CLS_ILLEGAL = 4'd15;

    // Sequencer states
    localparam int STATE_W = 4;

    localparam logic [STATE_W-1:0] ST_STACK_INIT  = 4'd0;
    localparam logic [STATE_W-1:0] ST_FETCH_WAIT  = 4'd1;
    localparam logic [STATE_W-1:0] ST_FETCH_LATCH = 4'd2;
    localparam logic [STATE_W-1:0] ST_DECODE      = 4'd3;
    localparam logic [STATE_W-1:0] ST_DISPATCH    = 4'd4;
    localparam logic [STATE_W-1:0] ST_ALU         = 4'd5;
    localparam logic [STATE_W-1:0] ST_LOAD_ADDR   = 4'd6;
    localparam logic [STATE_W-1:0] ST_MEM_READ    = 4'd7;
    localparam logic [STATE_W-1:0] ST_MDR_SEL     = 4'd8;
    localparam logic [STATE_W-1:0] ST_WRITEBACK   = 4'd9;
    localparam logic [STATE_W-1:0] ST_EXC_WAIT    = 4'd10;
    localparam logic [STATE_W-1:0] ST_EXC_COMMIT  = 4'd11;

    localparam logic [1:0] CAUSE_ILLEGAL  = 2'd0;
    localparam logic [1:0] CAUSE_OVERFLOW = 2'd1;

    // Wait counts in cycles
    localparam int CNT_W = 4;

    localparam logic [CNT_W-1:0] FETCH_WAIT_CYCLES = 4'd3;
    localparam logic [CNT_W-1:0] MEM_WAIT_CYCLES   = 4'd2;
    localparam logic [CNT_W-1:0] EXC_WAIT_CYCLES   = 4'd8;

    // Datapath control encodings
    localparam logic [2:0] ALUOP_ADD = 3'd1;
    localparam logic [2:0] ALUOP_AND = 3'd2;
    localparam logic [2:0] ALUOP_SUB = 3'd3;

    localparam logic [1:0] SRCA_PC = 2'd0;
    localparam logic [1:0] SRCA_A  = 2'd1;

    localparam logic [2:0] SRCB_B    = 3'd0;
    localparam logic [2:0] SRCB_FOUR = 3'd1;
    localparam logic [2:0] SRCB_IMM  = 3'd2;

    localparam logic [2:0] IORD_PC     = 3'd0;
    localparam logic [2:0] IORD_ALU    = 3'd1;
    localparam logic [2:0] IORD_VECTOR = 3'd2;

    localparam logic [2:0] PCSRC_ALU = 3'd0;
    localparam logic [2:0] PCSRC_EXC = 3'd3;

    localparam logic [1:0] REGDST_RT = 2'd0;
    localparam logic [1:0] REGDST_RD = 2'd1;
    localparam logic [1:0] REGDST_SP = 2'd2;

    localparam logic [3:0] TOREG_ALU       = 4'd0;
    localparam logic [3:0] TOREG_MDR       = 4'd1;
    localparam logic [3:0] TOREG_STACK_TOP = 4'd4;

    localparam logic [1:0] MDR_WORD = 2'd0;
    localparam logic [1:0] MDR_HALF = 2'd1;
    localparam logic [1:0] MDR_BYTE = 2'd2;

endpackage

//--- verilog/seq_if.sv
`timescale 1ns/1ps

interface seq_if (
    input logic clk
);

    logic [cu_pkg::STATE_W-1:0] state;
    logic [cu_pkg::CLS_W-1:0]   cls_q;
    logic [1:0]                 cause;
    // Low when the writeback must trap instead of writing
    logic                       wb_commit;

    modport seq (
        output state,
        output cls_q,
        output cause,
        output wb_commit
    );

    modport enc (
        input clk,
        input state,
        input cls_q,
        input cause,
        input wb_commit
    );

endinterface

//--- verilog/op_decoder.sv
`timescale 1ns/1ps

module op_decoder (
    input  logic [cu_pkg::OPCODE_W-1:0] opcode,
    input  logic [cu_pkg::FUNCT_W-1:0]  funct,
    output logic [cu_pkg::CLS_W-1:0]    cls
);

    always_comb begin
        cls = cu_pkg::CLS_ILLEGAL;
        case (opcode)
            cu_pkg::OP_RTYPE: begin
                // R-type is resolved by funct
                case (funct)
                    cu_pkg::FN_ADD: cls = cu_pkg::CLS_ADD;
                    cu_pkg::FN_AND: cls = cu_pkg::CLS_AND;
                    cu_pkg::FN_SUB: cls = cu_pkg::CLS_SUB;
                    default:        cls = cu_pkg::CLS_ILLEGAL;
                endcase
            end
            cu_pkg::OP_ADDI: begin
                cls = cu_pkg::CLS_ADDI;
            end
            cu_pkg::OP_ADDIU: begin
                cls = cu_pkg::CLS_ADDIU;
            end
            cu_pkg::OP_LW: begin
                cls = cu_pkg::CLS_LW;
            end
            cu_pkg::OP_LH: begin
                cls = cu_pkg::CLS_LH;
            end
            cu_pkg::OP_LB: begin
                cls = cu_pkg::CLS_LB;
            end
            default: begin
                cls = cu_pkg::CLS_ILLEGAL;
            end
        endcase
    end

endmodule

//--- verilog/state_sequencer.sv
`timescale 1ns/1ps

module state_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ov,
    input  logic [cu_pkg::CLS_W-1:0] cls,
    seq_if.seq                       status
);

    logic [cu_pkg::STATE_W-1:0] state;
    logic [cu_pkg::CNT_W-1:0]   cnt;
    logic [cu_pkg::CLS_W-1:0]   cls_q;
    logic [1:0]                 cause;
    logic                       ov_class;
    logic                       wb_commit;

    // Only signed adds trap on overflow
    assign ov_class = (cls_q == cu_pkg::CLS_ADD) ||
                      (cls_q == cu_pkg::CLS_SUB) ||
                      (cls_q == cu_pkg::CLS_ADDI);
    assign wb_commit = !(ov_class && ov);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cu_pkg::ST_STACK_INIT;
            cnt   <= '0;
            cls_q <= cu_pkg::CLS_ILLEGAL;
            cause <= cu_pkg::CAUSE_ILLEGAL;
        end else begin
            cnt <= '0;
            case (state)
                cu_pkg::ST_STACK_INIT: begin
                    state <= cu_pkg::ST_FETCH_WAIT;
                end
                cu_pkg::ST_FETCH_WAIT: begin
                    if (cnt == cu_pkg::FETCH_WAIT_CYCLES - 1'b1) begin
                        state <= cu_pkg::ST_FETCH_LATCH;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                cu_pkg::ST_FETCH_LATCH: begin
                    state <= cu_pkg::ST_DECODE;
                end
                cu_pkg::ST_DECODE: begin
                    state <= cu_pkg::ST_DISPATCH;
                end
                cu_pkg::ST_DISPATCH: begin
                    cls_q <= cls;
                    case (cls)
                        cu_pkg::CLS_ADD, cu_pkg::CLS_AND, cu_pkg::CLS_SUB,
                        cu_pkg::CLS_ADDI, cu_pkg::CLS_ADDIU: begin
                            state <= cu_pkg::ST_ALU;
                        end
                        cu_pkg::CLS_LW, cu_pkg::CLS_LH, cu_pkg::CLS_LB: begin
                            state <= cu_pkg::ST_LOAD_ADDR;
                        end
                        default: begin
                            state <= cu_pkg::ST_EXC_WAIT;
                            cause <= cu_pkg::CAUSE_ILLEGAL;
                        end
                    endcase
                end
                cu_pkg::ST_ALU: begin
                    state <= cu_pkg::ST_WRITEBACK;
                end
                cu_pkg::ST_LOAD_ADDR: begin
                    state <= cu_pkg::ST_MEM_READ;
                end
                cu_pkg::ST_MEM_READ: begin
                    if (cnt == cu_pkg::MEM_WAIT_CYCLES - 1'b1) begin
                        state <= cu_pkg::ST_MDR_SEL;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                cu_pkg::ST_MDR_SEL: begin
                    state <= cu_pkg::ST_WRITEBACK;
                end
                cu_pkg::ST_WRITEBACK: begin
                    if (wb_commit) begin
                        state <= cu_pkg::ST_FETCH_WAIT;
                    end else begin
                        state <= cu_pkg::ST_EXC_WAIT;
                        cause <= cu_pkg::CAUSE_OVERFLOW;
                    end
                end
                cu_pkg::ST_EXC_WAIT: begin
                    // Vector fetch from memory
                    if (cnt == cu_pkg::EXC_WAIT_CYCLES - 1'b1) begin
                        state <= cu_pkg::ST_EXC_COMMIT;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                cu_pkg::ST_EXC_COMMIT: begin
                    state <= cu_pkg::ST_FETCH_WAIT;
                end
                default: begin
                    state <= cu_pkg::ST_STACK_INIT;
                end
            endcase
        end
    end

    assign status.state     = state;
    assign status.cls_q     = cls_q;
    assign status.cause     = cause;
    assign status.wb_commit = wb_commit;

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {[cu_pkg::ST_STACK_INIT:cu_pkg::ST_EXC_COMMIT]});

    a_cnt_bound: assert property (@(posedge clk) disable iff (reset)
        cnt < cu_pkg::EXC_WAIT_CYCLES);

    // An illegal dispatch must never reach the ALU step
    a_alu_legal: assert property (@(posedge clk) disable iff (reset)
        (state == cu_pkg::ST_ALU) |-> (cls_q != cu_pkg::CLS_ILLEGAL));

endmodule

//--- verilog/control_encoder.sv
`timescale 1ns/1ps

module control_encoder (
    seq_if.enc         status,
    output logic       pc_write,
    output logic       ir_write,
    output logic       a_write,
    output logic       b_write,
    output logic       mdr_write,
    output logic       alureg_write,
    output logic       epc_write,
    output logic       reg_write,
    output logic [1:0] reg_dst,
    output logic [1:0] except,
    output logic [1:0] mem_to_mdr,
    output logic [1:0] alu_src_a,
    output logic [2:0] iord,
    output logic [2:0] alu_src_b,
    output logic [2:0] alu_op,
    output logic [2:0] pc_src,
    output logic [3:0] mem_toreg
);

    logic is_rtype;
    logic is_load;

    assign is_rtype = (status.cls_q == cu_pkg::CLS_ADD) ||
                      (status.cls_q == cu_pkg::CLS_AND) ||
                      (status.cls_q == cu_pkg::CLS_SUB);
    assign is_load  = (status.cls_q == cu_pkg::CLS_LW) ||
                      (status.cls_q == cu_pkg::CLS_LH) ||
                      (status.cls_q == cu_pkg::CLS_LB);

    always_comb begin
        pc_write     = 1'b0;
        ir_write     = 1'b0;
        a_write      = 1'b0;
        b_write      = 1'b0;
        mdr_write    = 1'b0;
        alureg_write = 1'b0;
        epc_write    = 1'b0;
        reg_write    = 1'b0;
        reg_dst      = cu_pkg::REGDST_RT;
        except       = cu_pkg::CAUSE_ILLEGAL;
        mem_to_mdr   = cu_pkg::MDR_WORD;
        alu_src_a    = cu_pkg::SRCA_PC;
        iord         = cu_pkg::IORD_PC;
        alu_src_b    = cu_pkg::SRCB_B;
        alu_op       = 3'd0;
        pc_src       = cu_pkg::PCSRC_ALU;
        mem_toreg    = cu_pkg::TOREG_ALU;
        case (status.state)
            cu_pkg::ST_STACK_INIT: begin
                // Load the stack pointer with the stack top
                reg_write = 1'b1;
                reg_dst   = cu_pkg::REGDST_SP;
                mem_toreg = cu_pkg::TOREG_STACK_TOP;
            end
            cu_pkg::ST_FETCH_WAIT, cu_pkg::ST_FETCH_LATCH, cu_pkg::ST_DECODE: begin
                // PC + 4 on the ALU through fetch and decode
                alu_src_b = cu_pkg::SRCB_FOUR;
                alu_op    = cu_pkg::ALUOP_ADD;
                pc_write  = (status.state == cu_pkg::ST_FETCH_LATCH);
                ir_write  = (status.state == cu_pkg::ST_FETCH_LATCH);
                a_write   = (status.state == cu_pkg::ST_DECODE);
                b_write   = (status.state == cu_pkg::ST_DECODE);
            end
            cu_pkg::ST_ALU: begin
                alu_src_a    = cu_pkg::SRCA_A;
                alu_src_b    = is_rtype ? cu_pkg::SRCB_B : cu_pkg::SRCB_IMM;
                alureg_write = 1'b1;
                case (status.cls_q)
                    cu_pkg::CLS_AND: alu_op = cu_pkg::ALUOP_AND;
                    cu_pkg::CLS_SUB: alu_op = cu_pkg::ALUOP_SUB;
                    default:         alu_op = cu_pkg::ALUOP_ADD;
                endcase
            end
            cu_pkg::ST_LOAD_ADDR: begin
                alu_src_a = cu_pkg::SRCA_A;
                alu_src_b = cu_pkg::SRCB_IMM;
                alu_op    = cu_pkg::ALUOP_ADD;
            end
            cu_pkg::ST_MEM_READ: begin
                iord = cu_pkg::IORD_ALU;
            end
            cu_pkg::ST_MDR_SEL: begin
                iord      = cu_pkg::IORD_ALU;
                mdr_write = 1'b1;
                case (status.cls_q)
                    cu_pkg::CLS_LH: mem_to_mdr = cu_pkg::MDR_HALF;
                    cu_pkg::CLS_LB: mem_to_mdr = cu_pkg::MDR_BYTE;
                    default:        mem_to_mdr = cu_pkg::MDR_WORD;
                endcase
            end
            cu_pkg::ST_WRITEBACK: begin
                reg_write = status.wb_commit;
                if (status.wb_commit) begin
                    reg_dst   = is_rtype ? cu_pkg::REGDST_RD : cu_pkg::REGDST_RT;
                    mem_toreg = is_load ? cu_pkg::TOREG_MDR : cu_pkg::TOREG_ALU;
                end
            end
            cu_pkg::ST_EXC_WAIT: begin
                except    = status.cause;
                iord      = cu_pkg::IORD_VECTOR;
                alu_src_b = cu_pkg::SRCB_FOUR;
                alu_op    = cu_pkg::ALUOP_AND;
            end
            cu_pkg::ST_EXC_COMMIT: begin
                epc_write = 1'b1;
                pc_write  = 1'b1;
                pc_src    = cu_pkg::PCSRC_EXC;
            end
            default: begin
            end
        endcase
    end

    a_pc_reg_excl: assert property (@(posedge status.clk)
        pc_write |-> !reg_write);

    // MDR loads only once the memory wait is over
    a_mdr_state: assert property (@(posedge status.clk)
        mdr_write |-> (status.state == cu_pkg::ST_MDR_SEL) &&
                      ($past(status.state) == cu_pkg::ST_MEM_READ));

endmodule

//--- verilog/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ov,
    input  logic [cu_pkg::OPCODE_W-1:0] opcode,
    input  logic [cu_pkg::FUNCT_W-1:0]  funct,
    output logic                        pc_write,
    output logic                        ir_write,
    output logic                        a_write,
    output logic                        b_write,
    output logic                        mdr_write,
    output logic                        alureg_write,
    output logic                        epc_write,
    output logic                        reg_write,
    output logic [1:0]                  reg_dst,
    output logic [1:0]                  except,
    output logic [1:0]                  mem_to_mdr,
    output logic [1:0]                  alu_src_a,
    output logic [2:0]                  iord,
    output logic [2:0]                  alu_src_b,
    output logic [2:0]                  alu_op,
    output logic [2:0]                  pc_src,
    output logic [3:0]                  mem_toreg
);

    logic [cu_pkg::CLS_W-1:0] cls;

    seq_if status (
        .clk (clk)
    );

    op_decoder u_op_decoder (
        .opcode (opcode),
        .funct  (funct),
        .cls    (cls)
    );

    state_sequencer u_state_sequencer (
        .clk    (clk),
        .reset  (reset),
        .ov     (ov),
        .cls    (cls),
        .status (status.seq)
    );

    control_encoder u_control_encoder (
        .status       (status.enc),
        .pc_write     (pc_write),
        .ir_write     (ir_write),
        .a_write      (a_write),
        .b_write      (b_write),
        .mdr_write    (mdr_write),
        .alureg_write (alureg_write),
        .epc_write    (epc_write),
        .reg_write    (reg_write),
        .reg_dst      (reg_dst),
        .except       (except),
        .mem_to_mdr   (mem_to_mdr),
        .alu_src_a    (alu_src_a),
        .iord         (iord),
        .alu_src_b    (alu_src_b),
        .alu_op       (alu_op),
        .pc_src       (pc_src),
        .mem_toreg    (mem_toreg)
    );

endmodule

//--- dv/tb_control_unit.sv
`timescale 1ns/1ps

module tb_control_unit;

    typedef enum logic [3:0] {
        PH_STACK, PH_FW, PH_FL, PH_DEC, PH_DISP, PH_ALU,
        PH_LA, PH_MR, PH_MS, PH_WB, PH_EXC, PH_COMMIT
    } phase_t;

    typedef struct packed {
        logic       pc_write;
        logic       ir_write;
        logic       a_write;
        logic       b_write;
        logic       mdr_write;
        logic       alureg_write;
        logic       epc_write;
        logic       reg_write;
        logic [1:0] reg_dst;
        logic [1:0] except;
        logic [1:0] mem_to_mdr;
        logic [1:0] alu_src_a;
        logic [2:0] iord;
        logic [2:0] alu_src_b;
        logic [2:0] alu_op;
        logic [2:0] pc_src;
        logic [3:0] mem_toreg;
    } ctrl_t;

    logic                        clk;
    logic                        reset;
    logic                        ov;
    logic [cu_pkg::OPCODE_W-1:0] opcode;
    logic [cu_pkg::FUNCT_W-1:0]  funct;
    ctrl_t                       got;

    // Stimulus table
    logic [cu_pkg::OPCODE_W-1:0] tbl_opcode[$];
    logic [cu_pkg::FUNCT_W-1:0]  tbl_funct[$];
    logic                        tbl_ov[$];
    logic [cu_pkg::CLS_W-1:0]    tbl_cls[$];

    phase_t steps[$];
    integer seed;
    int     check_count;
    int     mismatch_count;
    int     other_errors;
    bit     timed_out;
    int     idx;
    logic   rnd_ov;

    control_unit u_control_unit (
        .clk          (clk),
        .reset        (reset),
        .ov           (ov),
        .opcode       (opcode),
        .funct        (funct),
        .pc_write     (got.pc_write),
        .ir_write     (got.ir_write),
        .a_write      (got.a_write),
        .b_write      (got.b_write),
        .mdr_write    (got.mdr_write),
        .alureg_write (got.alureg_write),
        .epc_write    (got.epc_write),
        .reg_write    (got.reg_write),
        .reg_dst      (got.reg_dst),
        .except       (got.except),
        .mem_to_mdr   (got.mem_to_mdr),
        .alu_src_a    (got.alu_src_a),
        .iord         (got.iord),
        .alu_src_b    (got.alu_src_b),
        .alu_op       (got.alu_op),
        .pc_src       (got.pc_src),
        .mem_toreg    (got.mem_toreg)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic add_entry(input logic [cu_pkg::OPCODE_W-1:0] op,
                             input logic [cu_pkg::FUNCT_W-1:0] fn,
                             input logic ovv,
                             input logic [cu_pkg::CLS_W-1:0] c);
        tbl_opcode.push_back(op);
        tbl_funct.push_back(fn);
        tbl_ov.push_back(ovv);
        tbl_cls.push_back(c);
    endtask

    task automatic build_table();
        add_entry(cu_pkg::OP_RTYPE, cu_pkg::FN_ADD, 1'b0, cu_pkg::CLS_ADD);
        add_entry(cu_pkg::OP_RTYPE, cu_pkg::FN_AND, 1'b0, cu_pkg::CLS_AND);
        add_entry(cu_pkg::OP_RTYPE, cu_pkg::FN_SUB, 1'b0, cu_pkg::CLS_SUB);
        add_entry(cu_pkg::OP_ADDI, 6'h00, 1'b0, cu_pkg::CLS_ADDI);
        add_entry(cu_pkg::OP_ADDIU, 6'h00, 1'b0, cu_pkg::CLS_ADDIU);
        add_entry(cu_pkg::OP_LW, 6'h00, 1'b0, cu_pkg::CLS_LW);
        add_entry(cu_pkg::OP_LH, 6'h00, 1'b0, cu_pkg::CLS_LH);
        add_entry(cu_pkg::OP_LB, 6'h00, 1'b0, cu_pkg::CLS_LB);
        // Overflow cases
        add_entry(cu_pkg::OP_RTYPE, cu_pkg::FN_ADD, 1'b1, cu_pkg::CLS_ADD);
        add_entry(cu_pkg::OP_RTYPE, cu_pkg::FN_SUB, 1'b1, cu_pkg::CLS_SUB);
        add_entry(cu_pkg::OP_ADDI, 6'h00, 1'b1, cu_pkg::CLS_ADDI);
        add_entry(cu_pkg::OP_ADDIU, 6'h00, 1'b1, cu_pkg::CLS_ADDIU);
        // BEQ, J, SW, then MULT and SLL
        add_entry(6'h04, 6'h00, 1'b0, cu_pkg::CLS_ILLEGAL);
        add_entry(6'h02, 6'h00, 1'b0, cu_pkg::CLS_ILLEGAL);
        add_entry(6'h2b, 6'h00, 1'b0, cu_pkg::CLS_ILLEGAL);
        add_entry(cu_pkg::OP_RTYPE, 6'h18, 1'b0, cu_pkg::CLS_ILLEGAL);
        add_entry(cu_pkg::OP_RTYPE, 6'h00, 1'b0, cu_pkg::CLS_ILLEGAL);
    endtask

    function automatic bit is_rtype_cls(input logic [cu_pkg::CLS_W-1:0] c);
        return c == cu_pkg::CLS_ADD || c == cu_pkg::CLS_AND || c == cu_pkg::CLS_SUB;
    endfunction

    function automatic bit is_load_cls(input logic [cu_pkg::CLS_W-1:0] c);
        return c == cu_pkg::CLS_LW || c == cu_pkg::CLS_LH || c == cu_pkg::CLS_LB;
    endfunction

    function automatic bit traps_on_ov(input logic [cu_pkg::CLS_W-1:0] c);
        return c == cu_pkg::CLS_ADD || c == cu_pkg::CLS_SUB || c == cu_pkg::CLS_ADDI;
    endfunction

    // Expected controls for one step of the state table
    function automatic ctrl_t expected_controls(input phase_t ph,
                                                input logic [cu_pkg::CLS_W-1:0] c,
                                                input logic ovv);
        ctrl_t e;
        e = '0;
        case (ph)
            PH_STACK: begin
                e.reg_write = 1'b1;
                e.reg_dst   = cu_pkg::REGDST_SP;
                e.mem_toreg = cu_pkg::TOREG_STACK_TOP;
            end
            PH_FW: begin
                e.alu_src_b = cu_pkg::SRCB_FOUR;
                e.alu_op    = cu_pkg::ALUOP_ADD;
            end
            PH_FL: begin
                e.alu_src_b = cu_pkg::SRCB_FOUR;
                e.alu_op    = cu_pkg::ALUOP_ADD;
                e.pc_write  = 1'b1;
                e.ir_write  = 1'b1;
            end
            PH_DEC: begin
                e.alu_src_b = cu_pkg::SRCB_FOUR;
                e.alu_op    = cu_pkg::ALUOP_ADD;
                e.a_write   = 1'b1;
                e.b_write   = 1'b1;
            end
            PH_ALU: begin
                e.alu_src_a    = cu_pkg::SRCA_A;
                e.alu_src_b    = is_rtype_cls(c) ? cu_pkg::SRCB_B : cu_pkg::SRCB_IMM;
                e.alureg_write = 1'b1;
                if (c == cu_pkg::CLS_AND) begin
                    e.alu_op = cu_pkg::ALUOP_AND;
                end else if (c == cu_pkg::CLS_SUB) begin
                    e.alu_op = cu_pkg::ALUOP_SUB;
                end else begin
                    e.alu_op = cu_pkg::ALUOP_ADD;
                end
            end
            PH_LA: begin
                e.alu_src_a = cu_pkg::SRCA_A;
                e.alu_src_b = cu_pkg::SRCB_IMM;
                e.alu_op    = cu_pkg::ALUOP_ADD;
            end
            PH_MR: e.iord = cu_pkg::IORD_ALU;
            PH_MS: begin
                e.iord      = cu_pkg::IORD_ALU;
                e.mdr_write = 1'b1;
                if (c == cu_pkg::CLS_LH) begin
                    e.mem_to_mdr = cu_pkg::MDR_HALF;
                end else if (c == cu_pkg::CLS_LB) begin
                    e.mem_to_mdr = cu_pkg::MDR_BYTE;
                end
            end
            PH_WB: begin
                if (!(ovv && traps_on_ov(c))) begin
                    e.reg_write = 1'b1;
                    e.reg_dst   = is_rtype_cls(c) ? cu_pkg::REGDST_RD : cu_pkg::REGDST_RT;
                    e.mem_toreg = is_load_cls(c) ? cu_pkg::TOREG_MDR : cu_pkg::TOREG_ALU;
                end
            end
            PH_EXC: begin
                e.except    = (c == cu_pkg::CLS_ILLEGAL) ? cu_pkg::CAUSE_ILLEGAL
                                                         : cu_pkg::CAUSE_OVERFLOW;
                e.iord      = cu_pkg::IORD_VECTOR;
                e.alu_src_b = cu_pkg::SRCB_FOUR;
                e.alu_op    = cu_pkg::ALUOP_AND;
            end
            PH_COMMIT: begin
                e.epc_write = 1'b1;
                e.pc_write  = 1'b1;
                e.pc_src    = cu_pkg::PCSRC_EXC;
            end
            default: begin
            end
        endcase
        return e;
    endfunction

    task automatic check_strobe(input string name, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic check_select(input string name, input logic [3:0] actual,
                                input logic [3:0] expected);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic compare_step(input phase_t ph, input logic [cu_pkg::CLS_W-1:0] c,
                                input logic ovv);
        ctrl_t want;
        want = expected_controls(ph, c, ovv);
        check_strobe("pc_write", got.pc_write, want.pc_write);
        check_strobe("ir_write", got.ir_write, want.ir_write);
        check_strobe("a_write", got.a_write, want.a_write);
        check_strobe("b_write", got.b_write, want.b_write);
        check_strobe("mdr_write", got.mdr_write, want.mdr_write);
        check_strobe("alureg_write", got.alureg_write, want.alureg_write);
        check_strobe("epc_write", got.epc_write, want.epc_write);
        check_strobe("reg_write", got.reg_write, want.reg_write);
        check_select("reg_dst", 4'(got.reg_dst), 4'(want.reg_dst));
        check_select("except", 4'(got.except), 4'(want.except));
        check_select("mem_to_mdr", 4'(got.mem_to_mdr), 4'(want.mem_to_mdr));
        check_select("alu_src_a", 4'(got.alu_src_a), 4'(want.alu_src_a));
        check_select("iord", 4'(got.iord), 4'(want.iord));
        check_select("alu_src_b", 4'(got.alu_src_b), 4'(want.alu_src_b));
        check_select("alu_op", 4'(got.alu_op), 4'(want.alu_op));
        check_select("pc_src", 4'(got.pc_src), 4'(want.pc_src));
        check_select("mem_toreg", got.mem_toreg, want.mem_toreg);
    endtask

    task automatic queue_exception();
        for (int i = 0; i < int'(cu_pkg::EXC_WAIT_CYCLES); i++) begin
            steps.push_back(PH_EXC);
        end
        steps.push_back(PH_COMMIT);
    endtask

    // Steps from decode until the next fetch wait
    task automatic queue_steps(input logic [cu_pkg::CLS_W-1:0] c, input logic ovv);
        steps.delete();
        steps.push_back(PH_DEC);
        steps.push_back(PH_DISP);
        if (c == cu_pkg::CLS_ILLEGAL) begin
            queue_exception();
        end else if (is_load_cls(c)) begin
            steps.push_back(PH_LA);
            for (int i = 0; i < int'(cu_pkg::MEM_WAIT_CYCLES); i++) begin
                steps.push_back(PH_MR);
            end
            steps.push_back(PH_MS);
            steps.push_back(PH_WB);
        end else begin
            steps.push_back(PH_ALU);
            steps.push_back(PH_WB);
            if (ovv && traps_on_ov(c)) begin
                queue_exception();
            end
        end
    endtask

    task automatic wait_for_fetch();
        int waited;
        bit found;
        waited = 0;
        found  = 1'b0;
        while (!found && waited < 2 * int'(cu_pkg::EXC_WAIT_CYCLES)) begin
            @(negedge clk);
            if (got.ir_write === 1'b1) begin
                found = 1'b1;
            end else begin
                compare_step(PH_FW, cu_pkg::CLS_ILLEGAL, 1'b0);
                waited++;
            end
        end
        if (!found) begin
            other_errors++;
            timed_out = 1'b1;
            $display("Timeout at %0t: no ir_write pulse after %0d cycles", $time, waited);
        end else begin
            if (waited != int'(cu_pkg::FETCH_WAIT_CYCLES)) begin
                other_errors++;
                $display("Fetch wait at %0t lasted %0d cycles instead of %0d", $time, waited,
                         cu_pkg::FETCH_WAIT_CYCLES);
            end
            compare_step(PH_FL, cu_pkg::CLS_ILLEGAL, 1'b0);
        end
    endtask

    task automatic run_instruction(input int n, input logic ovv);
        logic [cu_pkg::CLS_W-1:0] c;
        c = tbl_cls[n];
        wait_for_fetch();
        if (timed_out) begin
            return;
        end
        // New word lands with the ir_write pulse
        opcode = tbl_opcode[n];
        funct  = tbl_funct[n];
        ov     = ovv;
        queue_steps(c, ovv);
        while (steps.size() > 0) begin
            @(negedge clk);
            compare_step(steps.pop_front(), c, ovv);
        end
    endtask

    initial begin
        seed           = 32'hdd0f_f60f;
        reset          = 1'b1;
        ov             = 1'b0;
        opcode         = '0;
        funct          = '0;
        check_count    = 0;
        mismatch_count = 0;
        other_errors   = 0;
        timed_out      = 1'b0;
        build_table();
        @(posedge clk);
        repeat (3) begin
            @(negedge clk);
            compare_step(PH_STACK, cu_pkg::CLS_ILLEGAL, 1'b0);
        end
        reset = 1'b0;
        for (int i = 0; i < tbl_cls.size(); i++) begin
            if (!timed_out) begin
                run_instruction(i, tbl_ov[i]);
            end
        end
        // Random order with random overflow
        for (int n = 0; n < 40; n++) begin
            idx    = ($random(seed) & 32'h7fff_ffff) % tbl_cls.size();
            rnd_ov = 1'($random(seed));
            if (!timed_out) begin
                run_instruction(idx, rnd_ov);
            end
        end
        $display("checks %0d, mismatches %0d, other errors %0d", check_count, mismatch_count,
                 other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
verilog/cu_pkg.sv
verilog/seq_if.sv
verilog/op_decoder.sv
verilog/state_sequencer.sv
verilog/control_encoder.sv
verilog/control_unit.sv
dv/tb_control_unit.sv

//--- run.sh
#!/bin/sh
# Compile and run the control unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f flist.f \
    --top-module tb_control_unit \
    -o sim_control_unit

./obj_dir/sim_control_unit > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "Failure found in sim.log"
    exit 1
fi

echo "Run complete, log in sim.log"
exit 0
